// File: compile.f
+incdir+.
dispatch_pkg.sv
branch_classify.sv
dispatch_queue.sv
mem_index_alloc.sv
busy_table.sv
dispatch.sv
tb_dispatch.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
    --top-module tb_dispatch -o tb_dispatch \
    && ./obj_dir/tb_dispatch | tee /dev/stderr | grep -x "All checks passed" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_dispatch.sv
`include "dispatch_consts.svh"

module tb_dispatch;
    timeunit 1ns;
    timeprecision 1ps;

    import dispatch_pkg::*;

    localparam int NUM_CYCLES = 4000;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int INT_FILL_LIMIT = `INT_DIS_SIZE - `FETCH_WIDTH;
    localparam int LOAD_FILL_LIMIT = `LOAD_DIS_SIZE - `FETCH_WIDTH;
    localparam int STORE_FILL_LIMIT = `STORE_DIS_SIZE - `FETCH_WIDTH;

    logic clk;
    logic rst;
    logic [`FETCH_WIDTH-1:0] op_valid;
    dis_op_t op [`FETCH_WIDTH];
    logic full;
    logic redirect;
    lq_idx_t lq_idx;
    sq_idx_t sq_idx;
    wakeup_t wakeup [`WAKEUP_PORTS];
    logic int_valid;
    int_issue_t int_data;
    logic int_rs1_ready;
    logic int_rs2_ready;
    logic int_issue_full;
    logic load_valid;
    mem_issue_t load_data;
    logic load_rs1_ready;
    logic load_issue_full;
    logic store_valid;
    mem_issue_t store_data;
    logic store_rs1_ready;
    logic store_rs2_ready;
    logic store_issue_full;

    // values chosen at the falling edge and driven at the next rising edge.
    logic [`FETCH_WIDTH-1:0] nxt_op_valid;
    dis_op_t nxt_op [`FETCH_WIDTH];
    logic nxt_redirect;
    lq_idx_t nxt_lq_idx;
    sq_idx_t nxt_sq_idx;
    wakeup_t nxt_wakeup [`WAKEUP_PORTS];
    logic nxt_int_full;
    logic nxt_load_full;
    logic nxt_store_full;

    int_issue_t exp_int [$];
    mem_issue_t exp_load [$];
    mem_issue_t exp_store [$];
    logic [`PREG_SIZE-1:0] model_busy;
    lq_idx_t model_lq_tail;
    sq_idx_t model_sq_tail;

    logic [31:0] lfsr;
    int issued_int;
    int issued_load;
    int issued_store;
    int redirects;

    dispatch i_dut (
        .clk(clk),
        .rst(rst),
        .op_valid_i(op_valid),
        .op_i(op),
        .full_o(full),
        .redirect_i(redirect),
        .lq_idx_i(lq_idx),
        .sq_idx_i(sq_idx),
        .wakeup_i(wakeup),
        .int_valid_o(int_valid),
        .int_data_o(int_data),
        .int_rs1_ready_o(int_rs1_ready),
        .int_rs2_ready_o(int_rs2_ready),
        .int_issue_full_i(int_issue_full),
        .load_valid_o(load_valid),
        .load_data_o(load_data),
        .load_rs1_ready_o(load_rs1_ready),
        .load_issue_full_i(load_issue_full),
        .store_valid_o(store_valid),
        .store_data_o(store_data),
        .store_rs1_ready_o(store_rs1_ready),
        .store_rs2_ready_o(store_rs2_ready),
        .store_issue_full_i(store_issue_full)
    );

    always #2 clk = ~clk;

    // fibonacci lfsr with taps 32, 22, 2 and 1, one step per bit taken.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic is_link(input areg_t r);
        return (r == areg_t'(`RA_REG)) || (r == areg_t'(`ALT_LINK_REG));
    endfunction

    function automatic br_type_e expected_br_type(input dis_op_t o);
        if (o.branch_op == BR_JAL) begin
            return DIRECT;
        end else if (o.branch_op == BR_JALR) begin
            return INDIRECT;
        end
        return CONDITION;
    endfunction

    function automatic ras_type_e expected_ras_type(input dis_op_t o);
        logic push;
        logic pop;
        push = is_link(o.arch_rd);
        pop = is_link(o.arch_rs1);
        if (o.branch_op == BR_JAL) begin
            return push ? PUSH : NONE;
        end else if (o.branch_op == BR_JALR) begin
            if (push && pop) begin
                return POP_PUSH;
            end else if (push) begin
                return PUSH;
            end else if (pop) begin
                return POP;
            end
        end
        return NONE;
    endfunction

    function automatic logic model_full();
        return (exp_int.size() > INT_FILL_LIMIT) || (exp_load.size() > LOAD_FILL_LIMIT)
            || (exp_store.size() > STORE_FILL_LIMIT);
    endfunction

    function automatic logic model_ready(input preg_t p);
        return (p == '0) || !model_busy[p];
    endfunction

    task automatic abort_run(input string why);
        $display("Checks failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_int(input string name, input int_issue_t exp, input int_issue_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run("integer issue entry mismatch");
        end
    endtask

    task automatic check_mem(input string name, input mem_issue_t exp, input mem_issue_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run("memory issue entry mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            abort_run("source ready bit mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            abort_run("valid or full level mismatch");
        end
    endtask

    task automatic check_outputs();
        check_flag("full_o", model_full(), full);
        check_flag("int_valid_o", exp_int.size() != 0, int_valid);
        check_flag("load_valid_o", exp_load.size() != 0, load_valid);
        check_flag("store_valid_o", exp_store.size() != 0, store_valid);
        if (exp_int.size() != 0) begin
            check_int("int head", exp_int[0], int_data);
            check_ready("int rs1 ready", model_ready(exp_int[0].prs1), int_rs1_ready);
            check_ready("int rs2 ready", model_ready(exp_int[0].prs2), int_rs2_ready);
        end
        if (exp_load.size() != 0) begin
            check_mem("load head", exp_load[0], load_data);
            check_ready("load rs1 ready", model_ready(exp_load[0].prs1), load_rs1_ready);
        end
        if (exp_store.size() != 0) begin
            check_mem("store head", exp_store[0], store_data);
            check_ready("store rs1 ready", model_ready(exp_store[0].prs1), store_rs1_ready);
            check_ready("store rs2 ready", model_ready(exp_store[0].prs2), store_rs2_ready);
        end
    endtask

    // applies the coming rising edge to the model, using the inputs now on the DUT.
    task automatic advance_model();
        logic accept;
        lq_idx_t lq;
        sq_idx_t sq;
        int_issue_t ie;
        mem_issue_t me;
        accept = !model_full() && !redirect;
        if (redirect) begin
            exp_int.delete();
            exp_load.delete();
            exp_store.delete();
            model_lq_tail = lq_idx;
            model_sq_tail = sq_idx;
            redirects++;
        end else begin
            if (exp_int.size() != 0 && !int_issue_full) begin
                void'(exp_int.pop_front());
                issued_int++;
            end
            if (exp_load.size() != 0 && !load_issue_full) begin
                void'(exp_load.pop_front());
                issued_load++;
            end
            if (exp_store.size() != 0 && !store_issue_full) begin
                void'(exp_store.pop_front());
                issued_store++;
            end
        end
        if (accept) begin
            lq = model_lq_tail;
            sq = model_sq_tail;
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                if (op_valid[s] && (op[s].op_class == CLS_LOAD || op[s].op_class == CLS_STORE))
                begin
                    me.prs1 = op[s].prs1;
                    me.prs2 = op[s].prs2;
                    me.prd = op[s].prd;
                    me.we = op[s].we;
                    me.rob_idx = op[s].rob_idx;
                    me.mem_op = op[s].mem_op;
                    me.imm = op[s].imm[`MEM_IMM_WIDTH-1:0];
                    me.lq_idx = lq;
                    me.sq_idx = sq;
                    if (op[s].op_class == CLS_LOAD) begin
                        exp_load.push_back(me);
                        lq = lq + lq_idx_t'(1);
                    end else begin
                        exp_store.push_back(me);
                        sq = sq + sq_idx_t'(1);
                    end
                end else if (op_valid[s]) begin
                    ie.prs1 = op[s].prs1;
                    ie.prs2 = op[s].prs2;
                    ie.prd = op[s].prd;
                    ie.we = op[s].we;
                    ie.rob_idx = op[s].rob_idx;
                    ie.imm = op[s].imm;
                    ie.br_type = expected_br_type(op[s]);
                    ie.ras_type = expected_ras_type(op[s]);
                    exp_int.push_back(ie);
                end
            end
            model_lq_tail = lq;
            model_sq_tail = sq;
        end
        // clears first, so a destination set in the same cycle stays busy.
        for (int w = 0; w < `WAKEUP_PORTS; w++) begin
            if (wakeup[w].valid) begin
                model_busy[wakeup[w].preg] = 1'b0;
            end
        end
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            if (accept && op_valid[s] && op[s].we && op[s].prd != '0) begin
                model_busy[op[s].prd] = 1'b1;
            end
        end
    endtask

    task automatic random_op(output dis_op_t o);
        logic [31:0] r;
        r = random_bits(2);
        o.op_class = op_class_e'(r[1:0]);
        o.branch_op = BR_COND;
        if (o.op_class == CLS_BRANCH) begin
            r = random_bits(2);
            o.branch_op = (r[1:0] == 2'd3) ? BR_JALR : branch_op_e'(r[1:0]);
        end
        r = random_bits(2);
        if (o.op_class == CLS_STORE) begin
            o.mem_op = (r[1:0] == 2'd3) ? MEM_SW : mem_op_e'({1'b1, r[1:0]});
        end else begin
            o.mem_op = mem_op_e'({1'b0, r[1:0]});
        end
        // small register ranges hit the link registers and busy pregs often.
        o.arch_rd = areg_t'(random_bits(3));
        o.arch_rs1 = areg_t'(random_bits(3));
        o.prs1 = preg_t'(random_bits(4));
        o.prs2 = preg_t'(random_bits(4));
        o.prd = preg_t'(random_bits(4));
        r = random_bits(1);
        o.we = r[0];
        o.rob_idx = rob_idx_t'(random_bits(`ROB_WIDTH));
        o.imm = `IMM_WIDTH'(random_bits(`IMM_WIDTH));
    endtask

    task automatic pick_inputs(input logic quiet, input int cycle);
        logic [31:0] r;
        logic heavy;
        heavy = ((cycle >> 7) & 1) != 0;
        nxt_redirect = !quiet && !redirect && (random_bits(5) == 32'd0);
        nxt_lq_idx = lq_idx_t'(random_bits(`LQ_WIDTH));
        nxt_sq_idx = sq_idx_t'(random_bits(`SQ_WIDTH));
        nxt_op_valid = '0;
        if (!quiet && !model_full() && random_bits(2) != 32'd0) begin
            r = random_bits(`FETCH_WIDTH);
            nxt_op_valid = r[`FETCH_WIDTH-1:0];
        end
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            random_op(nxt_op[s]);
        end
        for (int w = 0; w < `WAKEUP_PORTS; w++) begin
            r = random_bits(1);
            nxt_wakeup[w].valid = r[0];
            nxt_wakeup[w].preg = preg_t'(random_bits(4));
        end
        // long stretches of heavy back-pressure fill the queues up to full.
        nxt_int_full = !quiet && (heavy ? random_bits(2) != 32'd0 : random_bits(2) == 32'd0);
        nxt_load_full = !quiet && (heavy ? random_bits(2) != 32'd0 : random_bits(2) == 32'd0);
        nxt_store_full = !quiet && (heavy ? random_bits(2) != 32'd0 : random_bits(2) == 32'd0);
    endtask

    initial begin
        logic drained;
        lfsr = 32'h2bc0_b7d5;
        model_busy = '0;
        model_lq_tail = '0;
        model_sq_tail = '0;
        issued_int = 0;
        issued_load = 0;
        issued_store = 0;
        redirects = 0;
        drained = 1'b0;
        clk = 1'b0;
        rst <= 1'b1;
        op_valid <= '0;
        redirect <= 1'b0;
        lq_idx <= '0;
        sq_idx <= '0;
        int_issue_full <= 1'b0;
        load_issue_full <= 1'b0;
        store_issue_full <= 1'b0;
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            op[s] <= '0;
        end
        for (int w = 0; w < `WAKEUP_PORTS; w++) begin
            wakeup[w] <= '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int cycle = 0; cycle < NUM_CYCLES + DRAIN_TIMEOUT && !drained; cycle++) begin
            @(negedge clk);
            check_outputs();
            if (cycle >= NUM_CYCLES && exp_int.size() == 0 && exp_load.size() == 0
                && exp_store.size() == 0) begin
                drained = 1'b1;
            end else begin
                advance_model();
                pick_inputs(cycle >= NUM_CYCLES, cycle);
                @(posedge clk);
                op_valid <= nxt_op_valid;
                redirect <= nxt_redirect;
                lq_idx <= nxt_lq_idx;
                sq_idx <= nxt_sq_idx;
                int_issue_full <= nxt_int_full;
                load_issue_full <= nxt_load_full;
                store_issue_full <= nxt_store_full;
                for (int s = 0; s < `FETCH_WIDTH; s++) begin
                    op[s] <= nxt_op[s];
                end
                for (int w = 0; w < `WAKEUP_PORTS; w++) begin
                    wakeup[w] <= nxt_wakeup[w];
                end
            end
        end

        $display("issued %0d int, %0d load, %0d store ops across %0d redirects",
            issued_int, issued_load, issued_store, redirects);
        if (drained) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("queues still held entries %0d cycles after stimulus stopped",
                DRAIN_TIMEOUT);
            $display("Checks failed");
            $fatal(1, "drain timeout");
        end
    end

endmodule

// File: dispatch.sv
`include "dispatch_consts.svh"

module dispatch (
    input  logic clk,
    input  logic rst,
    input  logic [`FETCH_WIDTH-1:0] op_valid_i,
    input  dispatch_pkg::dis_op_t op_i [`FETCH_WIDTH],
    output logic full_o,
    input  logic redirect_i,
    input  dispatch_pkg::lq_idx_t lq_idx_i,
    input  dispatch_pkg::sq_idx_t sq_idx_i,
    input  dispatch_pkg::wakeup_t wakeup_i [`WAKEUP_PORTS],
    output logic int_valid_o,
    output dispatch_pkg::int_issue_t int_data_o,
    output logic int_rs1_ready_o,
    output logic int_rs2_ready_o,
    input  logic int_issue_full_i,
    output logic load_valid_o,
    output dispatch_pkg::mem_issue_t load_data_o,
    output logic load_rs1_ready_o,
    input  logic load_issue_full_i,
    output logic store_valid_o,
    output dispatch_pkg::mem_issue_t store_data_o,
    output logic store_rs1_ready_o,
    output logic store_rs2_ready_o,
    input  logic store_issue_full_i
);
    import dispatch_pkg::*;

    localparam int NUM_LOOKUP = 5;

    logic accept;
    logic int_full;
    logic load_full;
    logic store_full;
    logic [`FETCH_WIDTH-1:0] int_slot;
    logic [`FETCH_WIDTH-1:0] load_slot;
    logic [`FETCH_WIDTH-1:0] store_slot;
    logic [`FETCH_WIDTH-1:0] set_en;
    int_issue_t int_data [`FETCH_WIDTH];
    mem_issue_t mem_data [`FETCH_WIDTH];
    lq_idx_t lq_idx [`FETCH_WIDTH];
    sq_idx_t sq_idx [`FETCH_WIDTH];
    preg_t set_preg [`FETCH_WIDTH];
    preg_t lookup [NUM_LOOKUP];
    logic [NUM_LOOKUP-1:0] ready;

    // a group offered during a redirect is dropped.
    assign accept = !full_o && !redirect_i;
    assign full_o = int_full || load_full || store_full;

    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_slot
        br_type_e br_type;
        ras_type_e ras_type;

        branch_classify u_branch_classify (
            .op_i(op_i[i]),
            .br_type_o(br_type),
            .ras_type_o(ras_type)
        );

        assign int_slot[i] = op_valid_i[i]
            && (op_i[i].op_class == CLS_ALU || op_i[i].op_class == CLS_BRANCH);
        assign load_slot[i] = op_valid_i[i] && (op_i[i].op_class == CLS_LOAD);
        assign store_slot[i] = op_valid_i[i] && (op_i[i].op_class == CLS_STORE);

        assign set_en[i] = accept && op_valid_i[i] && op_i[i].we && (op_i[i].prd != '0);
        assign set_preg[i] = op_i[i].prd;

        assign int_data[i] = '{
            prs1: op_i[i].prs1,
            prs2: op_i[i].prs2,
            prd: op_i[i].prd,
            we: op_i[i].we,
            rob_idx: op_i[i].rob_idx,
            imm: op_i[i].imm,
            br_type: br_type,
            ras_type: ras_type
        };

        // loads and stores share one bundle and carry both indices.
        assign mem_data[i] = '{
            prs1: op_i[i].prs1,
            prs2: op_i[i].prs2,
            prd: op_i[i].prd,
            we: op_i[i].we,
            rob_idx: op_i[i].rob_idx,
            mem_op: op_i[i].mem_op,
            imm: op_i[i].imm[`MEM_IMM_WIDTH-1:0],
            lq_idx: lq_idx[i],
            sq_idx: sq_idx[i]
        };
    end

    mem_index_alloc u_mem_index_alloc (
        .clk(clk),
        .rst(rst),
        .redirect_i(redirect_i),
        .lq_idx_i(lq_idx_i),
        .sq_idx_i(sq_idx_i),
        .accept_i(accept),
        .load_slot_i(load_slot),
        .store_slot_i(store_slot),
        .lq_idx_o(lq_idx),
        .sq_idx_o(sq_idx)
    );

    dispatch_queue #(.entry_t(int_issue_t), .DEPTH(`INT_DIS_SIZE)) int_queue (
        .clk(clk),
        .rst(rst),
        .flush_i(redirect_i),
        .push_i(int_slot & {`FETCH_WIDTH{accept}}),
        .data_i(int_data),
        .full_o(int_full),
        .valid_o(int_valid_o),
        .data_o(int_data_o),
        .issue_full_i(int_issue_full_i)
    );

    dispatch_queue #(.entry_t(mem_issue_t), .DEPTH(`LOAD_DIS_SIZE)) load_queue (
        .clk(clk),
        .rst(rst),
        .flush_i(redirect_i),
        .push_i(load_slot & {`FETCH_WIDTH{accept}}),
        .data_i(mem_data),
        .full_o(load_full),
        .valid_o(load_valid_o),
        .data_o(load_data_o),
        .issue_full_i(load_issue_full_i)
    );

    dispatch_queue #(.entry_t(mem_issue_t), .DEPTH(`STORE_DIS_SIZE)) store_queue (
        .clk(clk),
        .rst(rst),
        .flush_i(redirect_i),
        .push_i(store_slot & {`FETCH_WIDTH{accept}}),
        .data_i(mem_data),
        .full_o(store_full),
        .valid_o(store_valid_o),
        .data_o(store_data_o),
        .issue_full_i(store_issue_full_i)
    );

    // head sources of all three queues read the busy table.
    assign lookup[0] = int_data_o.prs1;
    assign lookup[1] = int_data_o.prs2;
    assign lookup[2] = load_data_o.prs1;
    assign lookup[3] = store_data_o.prs1;
    assign lookup[4] = store_data_o.prs2;

    busy_table #(.NUM_LOOKUP(NUM_LOOKUP)) u_busy_table (
        .clk(clk),
        .rst(rst),
        .set_en_i(set_en),
        .set_preg_i(set_preg),
        .wakeup_i(wakeup_i),
        .lookup_i(lookup),
        .ready_o(ready)
    );

    assign int_rs1_ready_o = ready[0];
    assign int_rs2_ready_o = ready[1];
    assign load_rs1_ready_o = ready[2];
    assign store_rs1_ready_o = ready[3];
    assign store_rs2_ready_o = ready[4];

    // rename has to hold its group back while the stage is full.
    assert property (@(posedge clk) disable iff (rst) full_o |-> (op_valid_i == '0))
        else $error("dispatch: rename offered ops while full");

endmodule

// File: busy_table.sv
`include "dispatch_consts.svh"

module busy_table #(
    parameter int NUM_LOOKUP = 5
) (
    input  logic clk,
    input  logic rst,
    input  logic [`FETCH_WIDTH-1:0] set_en_i,
    input  dispatch_pkg::preg_t set_preg_i [`FETCH_WIDTH],
    input  dispatch_pkg::wakeup_t wakeup_i [`WAKEUP_PORTS],
    input  dispatch_pkg::preg_t lookup_i [NUM_LOOKUP],
    output logic [NUM_LOOKUP-1:0] ready_o
);
    import dispatch_pkg::*;

    logic [`PREG_SIZE-1:0] busy_q;
    logic [`PREG_SIZE-1:0] busy_n;

    // wakeups clear first so that a new destination in the same cycle
    // keeps its register busy.
    always_comb begin
        busy_n = busy_q;
        for (int w = 0; w < `WAKEUP_PORTS; w++) begin
            if (wakeup_i[w].valid) begin
                busy_n[wakeup_i[w].preg] = 1'b0;
            end
        end
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            if (set_en_i[s]) begin
                busy_n[set_preg_i[s]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_n;
        end
    end

    // x0 maps to preg 0, which is always ready.
    for (genvar j = 0; j < NUM_LOOKUP; j++) begin : g_lookup
        assign ready_o[j] = (lookup_i[j] == '0) || !busy_q[lookup_i[j]];
    end

    // dispatch never allocates preg 0 as a destination.
    assert property (@(posedge clk) disable iff (rst) !busy_q[0])
        else $error("busy_table: preg 0 marked busy");

endmodule

// File: mem_index_alloc.sv
`include "dispatch_consts.svh"

module mem_index_alloc (
    input  logic clk,
    input  logic rst,
    input  logic redirect_i,
    input  dispatch_pkg::lq_idx_t lq_idx_i,
    input  dispatch_pkg::sq_idx_t sq_idx_i,
    input  logic accept_i,
    input  logic [`FETCH_WIDTH-1:0] load_slot_i,
    input  logic [`FETCH_WIDTH-1:0] store_slot_i,
    output dispatch_pkg::lq_idx_t lq_idx_o [`FETCH_WIDTH],
    output dispatch_pkg::sq_idx_t sq_idx_o [`FETCH_WIDTH]
);
    import dispatch_pkg::*;

    lq_idx_t lq_tail_q;
    sq_idx_t sq_tail_q;
    lq_idx_t lq_cnt;
    sq_idx_t sq_cnt;

    // each slot sees the tail plus the loads or stores in the slots below it.
    // the index width wraps the sum at the queue size.
    always_comb begin
        lq_cnt = '0;
        sq_cnt = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            lq_idx_o[i] = lq_tail_q + lq_cnt;
            sq_idx_o[i] = sq_tail_q + sq_cnt;
            if (load_slot_i[i]) begin
                lq_cnt = lq_cnt + lq_idx_t'(1);
            end
            if (store_slot_i[i]) begin
                sq_cnt = sq_cnt + sq_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lq_tail_q <= '0;
            sq_tail_q <= '0;
        end else if (redirect_i) begin
            lq_tail_q <= lq_idx_i;
            sq_tail_q <= sq_idx_i;
        end else if (accept_i) begin
            lq_tail_q <= lq_tail_q + lq_cnt;
            sq_tail_q <= sq_tail_q + sq_cnt;
        end
    end

endmodule

// File: dispatch_queue.sv
`include "dispatch_consts.svh"

module dispatch_queue #(
    parameter type entry_t = logic,
    parameter int DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic flush_i,
    input  logic [`FETCH_WIDTH-1:0] push_i,
    input  entry_t data_i [`FETCH_WIDTH],
    output logic full_o,
    output logic valid_o,
    output entry_t data_o,
    input  logic issue_full_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] MAX_FILL = (PTR_W + 1)'(DEPTH - `FETCH_WIDTH);
    localparam logic [PTR_W:0] ONE = (PTR_W + 1)'(1);

    entry_t mem_q [DEPTH];

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0] count_q;

    logic [PTR_W:0] push_cnt;
    logic [PTR_W-1:0] wr_idx [`FETCH_WIDTH];
    logic pop;

    // pushing slots are packed behind the tail in slot order, so slot 0
    // lands ahead of slot 1 when both push.
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            wr_idx[i] = tail_q + push_cnt[PTR_W-1:0];
            if (push_i[i]) begin
                push_cnt = push_cnt + ONE;
            end
        end
    end

    assign valid_o = (count_q != '0);
    assign data_o = mem_q[head_q];
    assign pop = valid_o && !issue_full_i;

    // full as soon as a whole group might not fit.
    assign full_o = (count_q > MAX_FILL);

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (push_i[i]) begin
                mem_q[wr_idx[i]] <= data_i[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            head_q <= head_q + PTR_W'(pop);
            tail_q <= tail_q + push_cnt[PTR_W-1:0];
            count_q <= count_q + push_cnt - (PTR_W + 1)'(pop);
        end
    end

    // the stage must stop offering groups while this queue reports full.
    assert property (@(posedge clk) disable iff (rst) full_o |-> (push_i == '0))
        else $error("dispatch_queue: push while full");

endmodule

// File: branch_classify.sv
`include "dispatch_consts.svh"

module branch_classify (
    input  dispatch_pkg::dis_op_t op_i,
    output dispatch_pkg::br_type_e br_type_o,
    output dispatch_pkg::ras_type_e ras_type_o
);
    import dispatch_pkg::*;

    localparam areg_t RA = `RA_REG;
    localparam areg_t ALT_LINK = `ALT_LINK_REG;

    logic push;
    logic pop;
    ras_type_e link_ras;

    // a write to a link register pushes, a read from one pops.
    assign push = (op_i.arch_rd == RA) || (op_i.arch_rd == ALT_LINK);
    assign pop = (op_i.arch_rs1 == RA) || (op_i.arch_rs1 == ALT_LINK);

    always_comb begin
        case ({push, pop})
            2'b01: link_ras = POP;
            2'b10: link_ras = PUSH;
            2'b11: link_ras = POP_PUSH;
            default: link_ras = NONE;
        endcase
    end

    always_comb begin
        br_type_o = CONDITION;
        ras_type_o = NONE;
        if (op_i.branch_op == BR_JAL) begin
            br_type_o = DIRECT;
            ras_type_o = push ? PUSH : NONE;
        end else if (op_i.branch_op == BR_JALR) begin
            br_type_o = INDIRECT;
            ras_type_o = link_ras;
        end
    end

endmodule

// File: dispatch_pkg.sv
`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE
    } op_class_e;

    typedef enum logic [1:0] {
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_op_e;

    typedef enum logic [1:0] {
        DIRECT,
        INDIRECT,
        CONDITION
    } br_type_e;

    typedef enum logic [1:0] {
        NONE,
        POP,
        PUSH,
        POP_PUSH
    } ras_type_e;

    // the top bit marks a store.
    typedef enum logic [2:0] {
        MEM_LB  = 3'b000,
        MEM_LH  = 3'b001,
        MEM_LW  = 3'b010,
        MEM_LBU = 3'b011,
        MEM_SB  = 3'b100,
        MEM_SH  = 3'b101,
        MEM_SW  = 3'b110
    } mem_op_e;

    typedef logic [`PREG_WIDTH-1:0] preg_t;
    typedef logic [`AREG_WIDTH-1:0] areg_t;
    typedef logic [`ROB_WIDTH-1:0] rob_idx_t;
    typedef logic [`LQ_WIDTH-1:0] lq_idx_t;
    typedef logic [`SQ_WIDTH-1:0] sq_idx_t;

    typedef struct packed {
        op_class_e op_class;
        branch_op_e branch_op;
        mem_op_e mem_op;
        areg_t arch_rd;
        areg_t arch_rs1;
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        logic we;
        rob_idx_t rob_idx;
        logic [`IMM_WIDTH-1:0] imm;
    } dis_op_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        logic we;
        rob_idx_t rob_idx;
        logic [`IMM_WIDTH-1:0] imm;
        br_type_e br_type;
        ras_type_e ras_type;
    } int_issue_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        logic we;
        rob_idx_t rob_idx;
        mem_op_e mem_op;
        logic [`MEM_IMM_WIDTH-1:0] imm;
        lq_idx_t lq_idx;
        sq_idx_t sq_idx;
    } mem_issue_t;

    typedef struct packed {
        logic valid;
        preg_t preg;
    } wakeup_t;

endpackage

// File: dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// rename hands over this many ops per cycle.
`define FETCH_WIDTH 2

`define PREG_WIDTH 6
`define PREG_SIZE 64
`define AREG_WIDTH 5
`define ROB_WIDTH 5

`define IMM_WIDTH 20
`define MEM_IMM_WIDTH 12

`define LQ_WIDTH 4
`define SQ_WIDTH 4

// queue depths must be powers of two.
`define INT_DIS_SIZE 8
`define LOAD_DIS_SIZE 8
`define STORE_DIS_SIZE 8

`define WAKEUP_PORTS 2

// x1 and x5 are the link registers used for return-address-stack hints.
`define RA_REG 1
`define ALT_LINK_REG 5

`endif
